// ==== src/vdp_glue_pkg.sv ====
// ----------------------------------------
// shared widths and video standard tables
// ----------------------------------------
package vdp_glue_pkg;

    // colour component widths
    // vdp side is 6 bits per gun
    localparam int color_w = 6;
    // output side is a full byte per gun
    localparam int dvi_color_w = 8;

    // vdp beam coordinates
    localparam int vdp_pos_w = 11;
    // output raster coordinates, enough for 864 x 625
    localparam int raster_pos_w = 10;

    // number of supported video standards
    // index 0 ntsc, index 1 pal
    localparam int num_standards = 2;

    // ----------------------------------------
    // per-standard raster tables
    // ----------------------------------------

    // pixels per line, including blanking
    localparam logic [num_standards-1:0][raster_pos_w-1:0] h_total_tab = {
        10'd864,
        10'd858
    };

    // lines per frame
    localparam logic [num_standards-1:0][raster_pos_w-1:0] v_total_tab = {
        10'd625,
        10'd525
    };

    // line the counter parks on during a timing reset
    // puts the vdp active area inside the output frame
    localparam logic [num_standards-1:0][raster_pos_w-1:0] start_y_tab = {
        10'd570,
        10'd485
    };

endpackage

// ==== src/chip_select_filter.sv ====
`timescale 1ns/10ps

module chip_select_filter (
    input  logic clk_w,
    input  logic reset_n_w,
    input  logic csr_n,
    input  logic csw_n,
    output logic csr_n_filt,
    output logic csw_n_filt
);

    // two-flop synchronisers, bit 0 is the first stage
    logic [1:0] csr_sync;
    logic [1:0] csw_sync;

    // ----------------------------------------
    // synchroniser stages
    // ----------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            // selects are idle high
            csr_sync <= 2'b11;
            csw_sync <= 2'b11;
        end else begin
            csr_sync <= {csr_sync[0], csr_n};
            csw_sync <= {csw_sync[0], csw_n};
        end
    end

    // ----------------------------------------
    // hysteresis
    // ----------------------------------------
    // output only moves once both stages agree
    // a one-cycle glitch never fills both stages
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            csr_n_filt <= 1'b1;
            csw_n_filt <= 1'b1;
        end else begin
            if (csr_sync[0] == csr_sync[1]) begin
                csr_n_filt <= csr_sync[1];
            end
            if (csw_sync[0] == csw_sync[1]) begin
                csw_n_filt <= csw_sync[1];
            end
        end
    end

endmodule

// ==== src/cpu_access_sequencer.sv ====
`timescale 1ns/10ps

module cpu_access_sequencer
    import vdp_glue_pkg::*;
(
    input  logic       clk_w,
    input  logic       reset_n_w,
    input  logic       csr_n_filt,
    input  logic       csw_n_filt,
    input  logic [1:0] mode,
    input  logic [7:0] cdo,
    output logic       cpu_req,
    output logic       cpu_wrt,
    output logic [1:0] cpu_port,
    output logic [7:0] cpu_dbo
);

    typedef enum logic {
        st_idle,
        st_busy
    } seq_state_t;

    seq_state_t state;
    // chip-select pair seen at the last request
    logic [1:0] cs_latch;

    // ----------------------------------------
    // idle/busy fsm
    // ----------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            state    <= st_idle;
            cs_latch <= 2'b11;
            cpu_req  <= 1'b0;
            cpu_wrt  <= 1'b0;
        end else if (state == st_idle) begin
            // exactly one select low means an access
            cpu_req  <= csr_n_filt ^ csw_n_filt;
            // write only when csw alone is low
            cpu_wrt  <= csr_n_filt & ~csw_n_filt;
            cs_latch <= {csr_n_filt, csw_n_filt};
            state    <= st_busy;
        end else begin
            // request lasts one cycle only
            cpu_req <= 1'b0;
            cpu_wrt <= 1'b0;
            // wait for the selects to move before rearming
            if (cs_latch != {csr_n_filt, csw_n_filt}) begin
                state <= st_idle;
            end
        end
    end

    // port number and write data, captured with the request
    always_ff @(posedge clk_w) begin
        if (state == st_idle) begin
            cpu_port <= mode;
            cpu_dbo  <= cdo;
        end
    end

endmodule

// ==== src/video_sync_monitor.sv ====
`timescale 1ns/10ps

module video_sync_monitor
    import vdp_glue_pkg::*;
(
    input  logic                    clk_w,
    input  logic                    reset_n_w,
    input  logic [vdp_pos_w-1:0]    vdp_cx,
    input  logic [vdp_pos_w-1:0]    vdp_cy,
    input  logic                    vdp_pal_mode,
    input  logic                    vdp_hdmi_reset,
    input  logic [raster_pos_w-1:0] sel_cx,
    input  logic [raster_pos_w-1:0] sel_cy,
    output logic                    video_reset,
    output logic                    pal_mode
);

    logic vdp_at_origin;
    logic raster_at_origin;
    logic frame_mismatch;

    // vdp beam at top-left of its frame
    assign vdp_at_origin = (vdp_cx == '0) && (vdp_cy == '0);
    // active output raster at its own origin
    assign raster_at_origin = (sel_cx == '0) && (sel_cy == '0);
    // frames have drifted apart
    assign frame_mismatch = vdp_at_origin && !raster_at_origin;

    // ----------------------------------------
    // output timing reset
    // ----------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            video_reset <= 1'b0;
        end else begin
            // vdp request or resync, one cycle later
            video_reset <= vdp_hdmi_reset | frame_mismatch;
        end
    end

    // ----------------------------------------
    // pal/ntsc mode register
    // ----------------------------------------
    // only follows the vdp during a timing reset,
    // so the standard never switches mid-frame
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            pal_mode <= 1'b0;
        end else if (video_reset) begin
            pal_mode <= vdp_pal_mode;
        end
    end

endmodule

// ==== src/raster_counter.sv ====
`timescale 1ns/10ps

module raster_counter
    import vdp_glue_pkg::*;
#(
    parameter logic [raster_pos_w-1:0] h_total = 10'd858,
    parameter logic [raster_pos_w-1:0] v_total = 10'd525,
    parameter logic [raster_pos_w-1:0] start_y = 10'd485
) (
    input  logic                    clk_w,
    input  logic                    reset_n_w,
    input  logic                    video_reset,
    output logic [raster_pos_w-1:0] cx,
    output logic [raster_pos_w-1:0] cy
);

    logic line_end;
    logic frame_end;

    // last pixel of a line, last line of a frame
    assign line_end  = (cx == h_total - 1'b1);
    assign frame_end = (cy == v_total - 1'b1);

    // ----------------------------------------
    // position counters
    // ----------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            cx <= '0;
            cy <= start_y;
        end else if (video_reset) begin
            // park at start line until released
            cx <= '0;
            cy <= start_y;
        end else if (line_end) begin
            cx <= '0;
            // next line, wrap to top after the last one
            if (frame_end) begin
                cy <= '0;
            end else begin
                cy <= cy + 1'b1;
            end
        end else begin
            // one pixel per clock
            cx <= cx + 1'b1;
        end
    end

endmodule

// ==== src/pixel_formatter.sv ====
`timescale 1ns/10ps

module pixel_formatter
    import vdp_glue_pkg::*;
(
    input  logic                                       clk_w,
    input  logic                                       reset_n_w,
    input  logic                                       pal_mode,
    input  logic                                       scanlin_n,
    input  logic [color_w-1:0]                         video_r,
    input  logic [color_w-1:0]                         video_g,
    input  logic [color_w-1:0]                         video_b,
    input  logic [num_standards-1:0][raster_pos_w-1:0] cx,
    input  logic [num_standards-1:0][raster_pos_w-1:0] cy,
    output logic [raster_pos_w-1:0]                    sel_cx,
    output logic [raster_pos_w-1:0]                    sel_cy,
    output logic [raster_pos_w-1:0]                    raster_cx,
    output logic [raster_pos_w-1:0]                    raster_cy,
    output logic [dvi_color_w-1:0]                     dvi_r,
    output logic [dvi_color_w-1:0]                     dvi_g,
    output logic [dvi_color_w-1:0]                     dvi_b
);

    logic shade;

    // widen 6 to 8 bits, or half brightness when shaded
    function automatic logic [dvi_color_w-1:0] to_dvi(input logic [color_w-1:0] c,
                                                      input logic half);
        if (half) begin
            return {1'b0, c, {(dvi_color_w - color_w - 1){1'b0}}};
        end
        return {c, {(dvi_color_w - color_w){1'b0}}};
    endfunction

    // raster of the active standard, back to the sync monitor
    assign sel_cx = pal_mode ? cx[1] : cx[0];
    assign sel_cy = pal_mode ? cy[1] : cy[0];

    // darken odd lines when scanlines are on
    assign shade = ~scanlin_n & sel_cy[0];

    // registered raster position
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            raster_cx <= '0;
            raster_cy <= '0;
        end else begin
            raster_cx <= sel_cx;
            raster_cy <= sel_cy;
        end
    end

    // colour path, aligned with raster_cx/raster_cy
    always_ff @(posedge clk_w) begin
        dvi_r <= to_dvi(video_r, shade);
        dvi_g <= to_dvi(video_g, shade);
        dvi_b <= to_dvi(video_b, shade);
    end

endmodule

// ==== src/clock_divider.sv ====
`timescale 1ns/10ps

module clock_divider #(
    parameter int half_period = 7
) (
    input  logic clk_w,
    input  logic reset_n_w,
    output logic div_clk
);

    // at least one bit even for a divide by two
    localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;

    logic [cnt_w-1:0] cnt;

    // ----------------------------------------
    // toggle divider
    // ----------------------------------------
    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            cnt     <= '0;
            div_clk <= 1'b0;
        end else if (cnt == cnt_w'(half_period - 1)) begin
            // end of half period, flip and restart
            cnt     <= '0;
            div_clk <= ~div_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== src/vdp_glue_top.sv ====
`timescale 1ns/10ps

module vdp_glue_top
    import vdp_glue_pkg::*;
#(
    // 50 MHz over colourburst, halved
    parameter int cpu_clk_half_period = 7,
    parameter logic [num_standards-1:0][raster_pos_w-1:0] h_total_tab = vdp_glue_pkg::h_total_tab,
    parameter logic [num_standards-1:0][raster_pos_w-1:0] v_total_tab = vdp_glue_pkg::v_total_tab,
    parameter logic [num_standards-1:0][raster_pos_w-1:0] start_y_tab = vdp_glue_pkg::start_y_tab
) (
    input  logic                    clk_w,
    input  logic                    reset_n_w,
    // cpu bus
    input  logic                    csr_n,
    input  logic                    csw_n,
    input  logic [1:0]              mode,
    input  logic [7:0]              cdo,
    // vdp video side
    input  logic [vdp_pos_w-1:0]    vdp_cx,
    input  logic [vdp_pos_w-1:0]    vdp_cy,
    input  logic                    vdp_pal_mode,
    input  logic                    vdp_hdmi_reset,
    input  logic [color_w-1:0]      video_r,
    input  logic [color_w-1:0]      video_g,
    input  logic [color_w-1:0]      video_b,
    input  logic                    scanlin_n,
    // vdp register request
    output logic                    cpu_req,
    output logic                    cpu_wrt,
    output logic [1:0]              cpu_port,
    output logic [7:0]              cpu_dbo,
    // output video
    output logic [dvi_color_w-1:0]  dvi_r,
    output logic [dvi_color_w-1:0]  dvi_g,
    output logic [dvi_color_w-1:0]  dvi_b,
    output logic [raster_pos_w-1:0] raster_cx,
    output logic [raster_pos_w-1:0] raster_cy,
    output logic                    pal_mode,
    output logic                    video_reset,
    output logic                    cpu_clk
);

    // filtered chip selects
    logic csr_n_filt;
    logic csw_n_filt;

    // one raster per standard
    logic [num_standards-1:0][raster_pos_w-1:0] std_cx;
    logic [num_standards-1:0][raster_pos_w-1:0] std_cy;

    // active raster, fed back to the monitor
    logic [raster_pos_w-1:0] sel_cx;
    logic [raster_pos_w-1:0] sel_cy;

    // ----------------------------------------
    // cpu path
    // ----------------------------------------
    chip_select_filter u_cs_filter (
        .clk_w      (clk_w),
        .reset_n_w  (reset_n_w),
        .csr_n      (csr_n),
        .csw_n      (csw_n),
        .csr_n_filt (csr_n_filt),
        .csw_n_filt (csw_n_filt)
    );

    cpu_access_sequencer u_cpu_seq (
        .clk_w      (clk_w),
        .reset_n_w  (reset_n_w),
        .csr_n_filt (csr_n_filt),
        .csw_n_filt (csw_n_filt),
        .mode       (mode),
        .cdo        (cdo),
        .cpu_req    (cpu_req),
        .cpu_wrt    (cpu_wrt),
        .cpu_port   (cpu_port),
        .cpu_dbo    (cpu_dbo)
    );

    // ----------------------------------------
    // video path
    // ----------------------------------------
    video_sync_monitor u_sync_mon (
        .clk_w          (clk_w),
        .reset_n_w      (reset_n_w),
        .vdp_cx         (vdp_cx),
        .vdp_cy         (vdp_cy),
        .vdp_pal_mode   (vdp_pal_mode),
        .vdp_hdmi_reset (vdp_hdmi_reset),
        .sel_cx         (sel_cx),
        .sel_cy         (sel_cy),
        .video_reset    (video_reset),
        .pal_mode       (pal_mode)
    );

    // both standards run side by side, mode picks one
    for (genvar i = 0; i < num_standards; i++) begin : g_raster
        raster_counter #(
            .h_total (h_total_tab[i]),
            .v_total (v_total_tab[i]),
            .start_y (start_y_tab[i])
        ) u_raster (
            .clk_w       (clk_w),
            .reset_n_w   (reset_n_w),
            .video_reset (video_reset),
            .cx          (std_cx[i]),
            .cy          (std_cy[i])
        );
    end

    pixel_formatter u_formatter (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .pal_mode  (pal_mode),
        .scanlin_n (scanlin_n),
        .video_r   (video_r),
        .video_g   (video_g),
        .video_b   (video_b),
        .cx        (std_cx),
        .cy        (std_cy),
        .sel_cx    (sel_cx),
        .sel_cy    (sel_cy),
        .raster_cx (raster_cx),
        .raster_cy (raster_cy),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b)
    );

    // free-running cpu clock
    clock_divider #(
        .half_period (cpu_clk_half_period)
    ) u_cpu_clk_div (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .div_clk   (cpu_clk)
    );

endmodule

// ==== sim/tb_vdp_glue.sv ====
`timescale 1ns/10ps

module tb_vdp_glue
    import vdp_glue_pkg::*;
();

    // 8 ns clock
    localparam int clk_half = 4;
    // expected pal raster
    localparam int pal_h_total = 864;
    localparam int pal_v_total = 625;
    localparam int pal_start_y = 570;
    localparam int cpu_half = 7;
    localparam int frame_cycles = pal_h_total * pal_v_total;
    // two pal frames plus the short tests and margin
    localparam int watchdog_cycles = 2 * frame_cycles + 20000;

    logic clk_w;
    logic reset_n_w;
    logic csr_n;
    logic csw_n;
    logic [1:0] mode;
    logic [7:0] cdo;
    logic [vdp_pos_w-1:0] vdp_cx;
    logic [vdp_pos_w-1:0] vdp_cy;
    logic vdp_pal_mode;
    logic vdp_hdmi_reset;
    logic [color_w-1:0] video_r;
    logic [color_w-1:0] video_g;
    logic [color_w-1:0] video_b;
    logic scanlin_n;
    logic cpu_req;
    logic cpu_wrt;
    logic [1:0] cpu_port;
    logic [7:0] cpu_dbo;
    logic [dvi_color_w-1:0] dvi_r;
    logic [dvi_color_w-1:0] dvi_g;
    logic [dvi_color_w-1:0] dvi_b;
    logic [raster_pos_w-1:0] raster_cx;
    logic [raster_pos_w-1:0] raster_cy;
    logic pal_mode;
    logic video_reset;
    logic cpu_clk;

    // bookkeeping
    int error_count = 0;
    int first_error = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int seed_value;

    // colour checker state
    logic colour_on = 1'b0;
    logic prev_valid = 1'b0;
    logic prev_scan;
    logic shaded;
    logic [color_w-1:0] prev_r;
    logic [color_w-1:0] prev_g;
    logic [color_w-1:0] prev_b;
    int bright_checks = 0;
    int even_checks = 0;
    int odd_checks = 0;

    vdp_glue_top dut (.*);

    initial begin
        clk_w = 1'b0;
        forever #clk_half clk_w = ~clk_w;
    end

    // ----------------------------------------
    // checking helpers
    // ----------------------------------------
    task automatic check_value(input string test_name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Error: test %s expected %0d actual %0d", test_name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_cond(input string test_name, input bit cond, input string what);
        assert (cond) else begin
            $display("test %s: %s", test_name, what);
            error_count++;
        end
    endtask

    task automatic finish_test(input string test_name);
        tests_run++;
        if (error_count == first_error) begin
            $display("test %-8s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %-8s failed with %0d errors", test_name, error_count - first_error);
        end
        first_error = error_count;
    endtask

    // colour widened by two zero bits and halved on shaded lines
    function automatic logic [dvi_color_w-1:0] expected_colour(input logic [color_w-1:0] c,
                                                               input logic half);
        logic [dvi_color_w-1:0] wide;
        wide = {c, 2'b00};
        return half ? (wide >> 1) : wide;
    endfunction

    // dvi follows the colour sampled one edge earlier
    always @(negedge clk_w) begin : colour_checker
        if (colour_on && prev_valid) begin
            shaded = !prev_scan && raster_cy[0];
            check_value("colour", int'(expected_colour(prev_r, shaded)), int'(dvi_r));
            check_value("colour", int'(expected_colour(prev_g, shaded)), int'(dvi_g));
            check_value("colour", int'(expected_colour(prev_b, shaded)), int'(dvi_b));
            if (prev_scan) begin
                bright_checks++;
            end else if (shaded) begin
                odd_checks++;
            end else begin
                even_checks++;
            end
        end
        prev_valid = colour_on;
        prev_scan = scanlin_n;
        prev_r = video_r;
        prev_g = video_g;
        prev_b = video_b;
    end

    // ----------------------------------------
    // cpu path tests
    // ----------------------------------------
    task automatic cpu_access(input string test_name, input bit write);
        logic [1:0] exp_port;
        logic [7:0] exp_data;
        logic got_wrt;
        logic [1:0] got_port;
        logic [7:0] got_data;
        int req_seen;
        int req_cycle;
        exp_port = 2'($urandom);
        exp_data = 8'($urandom);
        req_seen = 0;
        req_cycle = 0;
        got_wrt = 1'b0;
        got_port = '0;
        got_data = '0;
        @(posedge clk_w);
        #1;
        mode = exp_port;
        cdo = exp_data;
        if (write) begin
            csw_n = 1'b0;
        end else begin
            csr_n = 1'b0;
        end
        // select held low for 10 cycles and then released
        for (int i = 1; i <= 20; i++) begin
            @(posedge clk_w);
            #1;
            if (i == 10) begin
                csw_n = 1'b1;
                csr_n = 1'b1;
            end
            @(negedge clk_w);
            if (cpu_req) begin
                req_seen++;
                if (req_seen == 1) begin
                    req_cycle = i;
                    got_wrt = cpu_wrt;
                    got_port = cpu_port;
                    got_data = cpu_dbo;
                end
            end
        end
        check_value(test_name, 1, req_seen);
        check_cond(test_name, req_cycle >= 4 && req_cycle <= 7,
                   "request outside the 4 to 7 cycle window");
        check_value(test_name, int'(write), int'(got_wrt));
        check_value(test_name, int'(exp_port), int'(got_port));
        if (write) begin
            check_value(test_name, int'(exp_data), int'(got_data));
        end
    endtask

    // single-cycle low on csw_n must be filtered out
    task automatic cs_glitch(input string test_name);
        int req_seen;
        req_seen = 0;
        @(posedge clk_w);
        #1;
        csw_n = 1'b0;
        @(posedge clk_w);
        #1;
        csw_n = 1'b1;
        repeat (15) begin
            @(negedge clk_w);
            if (cpu_req) begin
                req_seen++;
            end
        end
        check_value(test_name, 0, req_seen);
    endtask

    // starts right after reset release with no edge counted yet
    task automatic cpu_clock_period(input string test_name);
        logic last_level;
        int cycle;
        int last_edge;
        int toggles;
        last_level = cpu_clk;
        cycle = 0;
        last_edge = 0;
        toggles = 0;
        while (toggles < 5 && cycle < 100) begin
            @(negedge clk_w);
            cycle++;
            if (cpu_clk !== last_level) begin
                check_value(test_name, cpu_half, cycle - last_edge);
                last_edge = cycle;
                last_level = cpu_clk;
                toggles++;
            end
        end
        check_cond(test_name, toggles == 5, "cpu_clk stopped toggling");
    endtask

    // ----------------------------------------
    // video path tests
    // ----------------------------------------
    task automatic colour_run(input logic scan, input int cycles);
        repeat (cycles) begin
            @(posedge clk_w);
            #1;
            scanlin_n = scan;
            video_r = 6'($urandom);
            video_g = 6'($urandom);
            video_b = 6'($urandom);
        end
    endtask

    // pal switch through a vdp timing reset and one full frame
    task automatic pal_switch(input string test_name);
        int waited;
        int exp_cx;
        int exp_cy;
        int prev_cx;
        int prev_cy;
        int line_wraps;
        int frame_wraps;
        bit mismatch;
        @(posedge clk_w);
        #1;
        vdp_pal_mode = 1'b1;
        vdp_hdmi_reset = 1'b1;
        @(posedge clk_w);
        #1;
        vdp_hdmi_reset = 1'b0;
        waited = 0;
        while (!pal_mode && waited < 10) begin
            @(negedge clk_w);
            waited++;
        end
        check_cond(test_name, pal_mode, "pal_mode did not rise after the timing reset");
        // registered raster shows the parked position one cycle later
        @(negedge clk_w);
        check_value(test_name, 0, int'(raster_cx));
        check_value(test_name, pal_start_y, int'(raster_cy));
        exp_cx = 0;
        exp_cy = pal_start_y;
        prev_cx = int'(raster_cx);
        prev_cy = int'(raster_cy);
        line_wraps = 0;
        frame_wraps = 0;
        mismatch = 1'b0;
        // walk one frame through a pixel and line model
        for (int i = 0; i < frame_cycles && !mismatch; i++) begin
            @(negedge clk_w);
            exp_cx++;
            if (exp_cx == pal_h_total) begin
                exp_cx = 0;
                exp_cy++;
                if (exp_cy == pal_v_total) begin
                    exp_cy = 0;
                end
            end
            // wraps as seen on the dut raster
            if (int'(raster_cx) == 0 && prev_cx == pal_h_total - 1) begin
                line_wraps++;
            end
            if (int'(raster_cy) == 0 && prev_cy == pal_v_total - 1) begin
                frame_wraps++;
            end
            prev_cx = int'(raster_cx);
            prev_cy = int'(raster_cy);
            if (int'(raster_cx) != exp_cx || int'(raster_cy) != exp_cy) begin
                mismatch = 1'b1;
                check_value(test_name, exp_cx, int'(raster_cx));
                check_value(test_name, exp_cy, int'(raster_cy));
            end
        end
        check_value(test_name, pal_v_total, line_wraps);
        check_value(test_name, 1, frame_wraps);
    endtask

    // vdp origin while the raster is mid-frame
    task automatic resync(input string test_name);
        @(posedge clk_w);
        #1;
        vdp_cx = '0;
        vdp_cy = '0;
        @(negedge clk_w);
        check_value(test_name, 0, int'(video_reset));
        @(posedge clk_w);
        #1;
        vdp_cx = 11'd1;
        vdp_cy = 11'd1;
        @(negedge clk_w);
        check_value(test_name, 1, int'(video_reset));
        @(negedge clk_w);
        check_value(test_name, 0, int'(video_reset));
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed_value = $urandom(23673);
        reset_n_w = 1'b0;
        csr_n = 1'b1;
        csw_n = 1'b1;
        mode = '0;
        cdo = '0;
        // vdp beam away from its origin by default
        vdp_cx = 11'd1;
        vdp_cy = 11'd1;
        vdp_pal_mode = 1'b0;
        vdp_hdmi_reset = 1'b0;
        video_r = '0;
        video_g = '0;
        video_b = '0;
        scanlin_n = 1'b1;
        repeat (5) @(posedge clk_w);
        #1;
        reset_n_w = 1'b1;

        // state right after reset
        @(negedge clk_w);
        check_value("reset", 0, int'(cpu_req));
        check_value("reset", 0, int'(cpu_wrt));
        check_value("reset", 0, int'(video_reset));
        check_value("reset", 0, int'(pal_mode));
        check_value("reset", 0, int'(cpu_clk));
        finish_test("reset");
        cpu_clock_period("cpu_clk");
        finish_test("cpu_clk");

        repeat (3) cpu_access("write", 1'b1);
        finish_test("write");
        cpu_access("read", 1'b0);
        cs_glitch("read");
        finish_test("read");

        // plain colours first and scanlines across both line parities
        @(posedge clk_w);
        #1;
        colour_on = 1'b1;
        colour_run(1'b1, 200);
        colour_run(1'b0, 2 * 858 + 20);
        colour_on = 1'b0;
        check_cond("colour", bright_checks > 0, "no colour checked with scanlines off");
        check_cond("colour", even_checks > 0, "no even line checked with scanlines on");
        check_cond("colour", odd_checks > 0, "no odd line checked with scanlines on");
        finish_test("colour");

        pal_switch("mode");
        finish_test("mode");
        resync("resync");
        finish_test("resync");

        repeat (4) @(negedge clk_w);
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // run limit from the test lengths
    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_w);
        $display("watchdog: simulation did not finish within %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/vdp_glue_pkg.sv
src/chip_select_filter.sv
src/cpu_access_sequencer.sv
src/video_sync_monitor.sv
src/raster_counter.sv
src/pixel_formatter.sv
src/clock_divider.sv
src/vdp_glue_top.sv
sim/tb_vdp_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the vdp glue testbench with verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

# build the simulation executable
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_vdp_glue -f filelist.f -o tb_vdp_glue
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# run, keep the log for the result search
./obj_dir/tb_vdp_glue > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# any fail message in the log means a failed run
if grep -q "Test FAILED" "$log_file"; then
    exit 1
fi
exit 0
